//--- drop_fifo.f
+incdir+include
verilog/drop_fifo_pkg.sv
verilog/drop_fifo_if.sv
verilog/drop_fifo_ctrl.sv
verilog/drop_fifo_ptrs.sv
verilog/drop_fifo_mem.sv
verilog/drop_fifo_top.sv
testbench/drop_fifo_checker.sv
testbench/drop_fifo_tb.sv

//--- include/drop_fifo_defs.svh
// Drop FIFO sizing macros

`ifndef DROP_FIFO_DEFS_SVH
`define DROP_FIFO_DEFS_SVH

// ------------------------------
// Storage geometry
// ------------------------------

// Bits per stored entry
`define DROP_FIFO_DATA_WIDTH 8

// Entry count, kept a power of two
`define DROP_FIFO_DEPTH 16

// Index width into the array
// Pointers carry one extra wrap bit on top of this
`define DROP_FIFO_ADDR_WIDTH $clog2(`DROP_FIFO_DEPTH)

`endif

//--- testbench/drop_fifo_checker.sv
// Drop FIFO protocol checker
`timescale 1ns/1ps

`include "drop_fifo_defs.svh"

module drop_fifo_checker (
    input logic                       axi_aclk,
    input logic                       axi_aresetn,
    input logic                       i_wr_ready,
    input logic                       i_rd_valid,
    input drop_fifo_pkg::fifo_count_t i_count,
    input logic                       i_drop_valid,
    input logic                       i_drop_ready,
    input drop_fifo_pkg::fifo_count_t i_drop_count,
    input logic                       i_drop_all
);

    // Assertion failures seen so far
    int unsigned err_count = 0;

    // Mirror of the drop handshake, high from acceptance until release
    logic r_busy;
    logic w_accept;

    // Request is taken only when no drop is in flight
    assign w_accept = i_drop_valid && !r_busy;

    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            r_busy <= 1'b0;
        end else if (w_accept) begin
            r_busy <= 1'b1;
        end else if (i_drop_ready && !i_drop_valid) begin
            // Done state left once the request is seen low
            r_busy <= 1'b0;
        end
    end

    // ------------------------------
    // Flag rules
    // ------------------------------
    a_full_blocks_write: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (i_count == `DROP_FIFO_DEPTH) |-> !i_wr_ready)
        else begin err_count++; $error("Write port open while full"); end

    a_empty_blocks_read: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (i_count == 0) |-> !i_rd_valid)
        else begin err_count++; $error("Read valid while empty"); end

    // ------------------------------
    // Drop handshake rules
    // ------------------------------

    // Ack two edges after the sampling edge
    a_ack_latency: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        w_accept |=> !i_drop_ready ##1 !i_drop_ready ##1 i_drop_ready)
        else begin err_count++; $error("Drop ack latency wrong"); end

    // Active and settle cycles keep both ports shut
    a_freeze_ports: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        w_accept |=> (!i_wr_ready && !i_rd_valid) [*2])
        else begin err_count++; $error("Data port moved during drop"); end

    a_ack_holds: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (i_drop_ready && i_drop_valid) |=> i_drop_ready)
        else begin err_count++; $error("Drop ack fell while request held"); end

    // Partial drop never asks for more than is stored
    a_count_in_range: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (w_accept && !i_drop_all) |-> (i_drop_count <= i_count))
        else begin err_count++; $error("Drop count above occupancy"); end

endmodule : drop_fifo_checker

bind drop_fifo_top drop_fifo_checker u_checker (
    .axi_aclk     (axi_aclk),
    .axi_aresetn  (axi_aresetn),
    .i_wr_ready   (o_wr_ready),
    .i_rd_valid   (o_rd_valid),
    .i_count      (o_count),
    .i_drop_valid (i_drop_valid),
    .i_drop_ready (o_drop_ready),
    .i_drop_count (i_drop_count),
    .i_drop_all   (i_drop_all)
);

//--- testbench/drop_fifo_tb.sv
// Drop FIFO testbench
`timescale 1ns/1ps

`include "drop_fifo_defs.svh"

module drop_fifo_tb;

    // Several times the length of all tests together
    localparam int TIMEOUT_CYCLES = 4000;

    logic                       axi_aclk;
    logic                       axi_aresetn;
    logic                       i_wr_valid;
    logic                       o_wr_ready;
    drop_fifo_pkg::fifo_data_t  i_wr_data;
    logic                       i_rd_ready;
    logic                       o_rd_valid;
    drop_fifo_pkg::fifo_data_t  o_rd_data;
    drop_fifo_pkg::fifo_count_t o_count;
    logic                       i_drop_valid;
    logic                       o_drop_ready;
    drop_fifo_pkg::fifo_count_t i_drop_count;
    logic                       i_drop_all;

    // Reference contents with the oldest entry first
    drop_fifo_pkg::fifo_data_t model[$];
    string                     test_name;
    int unsigned               cycle_count = 0;

    drop_fifo_top dut (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .i_wr_valid   (i_wr_valid),
        .o_wr_ready   (o_wr_ready),
        .i_wr_data    (i_wr_data),
        .i_rd_ready   (i_rd_ready),
        .o_rd_valid   (o_rd_valid),
        .o_rd_data    (o_rd_data),
        .o_count      (o_count),
        .i_drop_valid (i_drop_valid),
        .o_drop_ready (o_drop_ready),
        .i_drop_count (i_drop_count),
        .i_drop_all   (i_drop_all)
    );

    initial begin
        axi_aclk = 1'b0;
        forever #4 axi_aclk = ~axi_aclk;
    end

    // ------------------------------
    // Failure handling
    // ------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic report_mismatch(input string what, input int unsigned exp_val,
                                   input int unsigned act_val);
        abort_run($sformatf("** Error [%s] %s: expected %0h, actual %0h",
                            test_name, what, exp_val, act_val));
    endtask

    // Run limit
    always @(posedge axi_aclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: run went past the cycle limit");
        end
    end

    // Stop on the first protocol checker failure
    always @(negedge axi_aclk) begin
        if (dut.u_checker.err_count != 0) begin
            abort_run("Protocol checker flagged an assertion failure");
        end
    end

    // ------------------------------
    // Model compare and traffic
    // ------------------------------
    task automatic check_outputs();
        int unsigned exp_size;
        exp_size = model.size();
        assert (o_count == drop_fifo_pkg::fifo_count_t'(exp_size))
            else report_mismatch("o_count", exp_size, o_count);
        assert (o_rd_valid == (exp_size != 0))
            else report_mismatch("o_rd_valid", exp_size != 0, o_rd_valid);
        assert (o_wr_ready == (exp_size != `DROP_FIFO_DEPTH))
            else report_mismatch("o_wr_ready", exp_size != `DROP_FIFO_DEPTH, o_wr_ready);
        if (exp_size != 0) begin
            assert (o_rd_data == model[0])
                else report_mismatch("o_rd_data", model[0], o_rd_data);
        end
    endtask

    // Model takes the transfers due at the next rising edge
    task automatic step(input logic wr, input logic rd);
        drop_fifo_pkg::fifo_data_t data;
        int unsigned               level;
        @(negedge axi_aclk);
        check_outputs();
        level      = model.size();
        data       = drop_fifo_pkg::fifo_data_t'($urandom);
        i_wr_valid = wr;
        i_wr_data  = data;
        i_rd_ready = rd;
        if (rd && (level != 0)) begin
            void'(model.pop_front());
        end
        if (wr && (level != `DROP_FIFO_DEPTH)) begin
            model.push_back(data);
        end
    endtask

    task automatic fill_to(input int unsigned level);
        while (model.size() < level) begin
            step(1'b1, 1'b0);
        end
    endtask

    task automatic drain_to(input int unsigned level);
        while (model.size() > level) begin
            step(1'b0, 1'b1);
        end
    endtask

    // Drop handshake with the ack expected on the third falling edge
    task automatic run_drop(input logic all, input int unsigned num);
        int unsigned edges;
        @(negedge axi_aclk);
        check_outputs();
        i_wr_valid   = 1'b0;
        i_rd_ready   = 1'b0;
        i_drop_valid = 1'b1;
        i_drop_all   = all;
        i_drop_count = drop_fifo_pkg::fifo_count_t'(num);
        edges        = 0;
        do begin
            @(negedge axi_aclk);
            edges++;
            if (!o_drop_ready) begin
                assert (!o_wr_ready && !o_rd_valid)
                    else abort_run("Data ports not frozen during drop");
                // Offer traffic the freeze must hold off
                i_wr_valid = 1'b1;
                i_rd_ready = 1'b1;
            end
        end while (!o_drop_ready && edges < 8);
        if (!o_drop_ready) begin
            abort_run("Drop acknowledge never arrived");
        end
        assert (edges == 3) else report_mismatch("ack latency", 3, edges);
        i_wr_valid = 1'b0;
        i_rd_ready = 1'b0;
        if (all) begin
            model.delete();
        end else begin
            repeat (num) void'(model.pop_front());
        end
        check_outputs();
        // Ack stays up while the request is held
        @(negedge axi_aclk);
        assert (o_drop_ready) else abort_run("Drop acknowledge fell while request held");
        check_outputs();
        i_drop_valid = 1'b0;
        @(negedge axi_aclk);
        assert (!o_drop_ready) else abort_run("Drop acknowledge stayed up after release");
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        void'($urandom(32'h4e92));
        axi_aresetn  = 1'b0;
        i_wr_valid   = 1'b0;
        i_wr_data    = '0;
        i_rd_ready   = 1'b0;
        i_drop_valid = 1'b0;
        i_drop_count = '0;
        i_drop_all   = 1'b0;
        test_name    = "reset";
        repeat (8) @(negedge axi_aclk);
        axi_aresetn = 1'b1;

        test_name = "ordered_flow";
        repeat (300) step(($urandom % 4) != 0, ($urandom % 2) == 1);

        // Extra pushes and pops past the limits must be refused
        test_name = "full_empty";
        fill_to(`DROP_FIFO_DEPTH);
        repeat (3) step(1'b1, 1'b0);
        drain_to(0);
        repeat (3) step(1'b0, 1'b1);

        // Rounds walk the read pointer across the wrap
        test_name = "drop_count";
        fill_to(10);
        run_drop(1'b0, 3);
        repeat (2) step(1'b0, 1'b1);
        for (int round = 0; round < 4; round++) begin
            fill_to(14);
            run_drop(1'b0, 4 + round * 3);
            repeat (3) step(1'b0, 1'b1);
        end
        fill_to(`DROP_FIFO_DEPTH);
        run_drop(1'b0, `DROP_FIFO_DEPTH);

        test_name = "drop_all";
        fill_to(7);
        run_drop(1'b1, 0);
        step(1'b1, 1'b0);
        step(1'b0, 1'b1);
        step(1'b0, 1'b0);
        run_drop(1'b1, 0);
        step(1'b0, 1'b0);

        if (dut.u_checker.err_count != 0) begin
            abort_run("Protocol checker flagged an assertion failure");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule : drop_fifo_tb

//--- verilog/drop_fifo_ctrl.sv
// Drop request controller
`timescale 1ns/1ps

module drop_fifo_ctrl (
    input  logic                       axi_aclk,
    input  logic                       axi_aresetn,
    input  logic                       i_drop_valid,
    input  logic                       i_drop_all,
    input  drop_fifo_pkg::fifo_count_t i_drop_count,
    output logic                       o_drop_ready,
    drop_cmd_if.ctrl                   cmd
);

    // Current and next drop state
    drop_fifo_pkg::drop_state_t r_state;
    drop_fifo_pkg::drop_state_t w_state_next;

    // Request accepted this cycle
    logic                       w_accept;

    // Request fields held for the whole drop
    logic                       r_drop_all;
    drop_fifo_pkg::fifo_count_t r_drop_count;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            r_state <= drop_fifo_pkg::DROP_IDLE;
        end else begin
            r_state <= w_state_next;
        end
    end

    // Only a request seen in idle starts a drop
    assign w_accept = i_drop_valid && (r_state == drop_fifo_pkg::DROP_IDLE);

    always_comb begin
        w_state_next = r_state;
        case (r_state)
            drop_fifo_pkg::DROP_IDLE: begin
                if (i_drop_valid) begin
                    w_state_next = drop_fifo_pkg::DROP_ACTIVE;
                end
            end
            // Pointer moves on the way out of here
            drop_fifo_pkg::DROP_ACTIVE: w_state_next = drop_fifo_pkg::DROP_SETTLE;
            // Dead cycle so count and flags are stable before ack
            drop_fifo_pkg::DROP_SETTLE: w_state_next = drop_fifo_pkg::DROP_DONE;
            drop_fifo_pkg::DROP_DONE: begin
                // Hold ack until requester lets go
                if (!i_drop_valid) begin
                    w_state_next = drop_fifo_pkg::DROP_IDLE;
                end
            end
            default: w_state_next = drop_fifo_pkg::DROP_IDLE;
        endcase
    end

    // ------------------------------
    // Request capture
    // ------------------------------
    always_ff @(posedge axi_aclk) begin
        if (w_accept) begin
            r_drop_all   <= i_drop_all;
            r_drop_count <= i_drop_count;
        end
    end

    // State decodes
    assign cmd.freeze     = (r_state == drop_fifo_pkg::DROP_ACTIVE) ||
                            (r_state == drop_fifo_pkg::DROP_SETTLE);
    assign cmd.adjust     = (r_state == drop_fifo_pkg::DROP_ACTIVE);
    assign cmd.drop_all   = r_drop_all;
    assign cmd.drop_count = r_drop_count;
    assign o_drop_ready   = (r_state == drop_fifo_pkg::DROP_DONE);

endmodule : drop_fifo_ctrl

//--- verilog/drop_fifo_if.sv
// Drop FIFO internal interfaces
`timescale 1ns/1ps

`include "drop_fifo_defs.svh"

// ------------------------------
// Drop command, ctrl to ptrs
// ------------------------------
interface drop_cmd_if;
    // Both data ports held off
    logic                       freeze;
    // Single cycle read pointer move
    logic                       adjust;
    // Latched request fields
    logic                       drop_all;
    drop_fifo_pkg::fifo_count_t drop_count;

    modport ctrl (output freeze, output adjust, output drop_all, output drop_count);
    modport ptrs (input freeze, input adjust, input drop_all, input drop_count);
endinterface : drop_cmd_if

// ------------------------------
// Storage access, ptrs to mem
// ------------------------------
interface fifo_mem_if;
    logic                              wr_en;
    logic [`DROP_FIFO_ADDR_WIDTH-1:0]  wr_addr;
    logic [`DROP_FIFO_ADDR_WIDTH-1:0]  rd_addr;
    // Data legs hooked up at the top level
    drop_fifo_pkg::fifo_data_t         wr_data;
    drop_fifo_pkg::fifo_data_t         rd_data;

    modport ptrs (output wr_en, output wr_addr, output rd_addr);
    modport mem (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );
endinterface : fifo_mem_if

//--- verilog/drop_fifo_mem.sv
// FIFO storage array
`timescale 1ns/1ps

`include "drop_fifo_defs.svh"

module drop_fifo_mem (
    input  logic     axi_aclk,
    fifo_mem_if.mem  mem
);

    // ------------------------------
    // Array
    // ------------------------------

    // Plain entries, contents only matter once written
    drop_fifo_pkg::fifo_data_t r_mem [`DROP_FIFO_DEPTH];

    // Write lands on the transfer edge
    always_ff @(posedge axi_aclk) begin
        if (mem.wr_en) begin
            r_mem[mem.wr_addr] <= mem.wr_data;
        end
    end

    // ------------------------------
    // Read
    // ------------------------------

    // Zero latency, follows the read pointer
    // Same-cycle data with rd_valid
    assign mem.rd_data = r_mem[mem.rd_addr];

endmodule : drop_fifo_mem

//--- verilog/drop_fifo_pkg.sv
// Drop FIFO shared types

`include "drop_fifo_defs.svh"

package drop_fifo_pkg;

    // ------------------------------
    // Payload and pointer types
    // ------------------------------

    // One stored entry
    typedef logic [`DROP_FIFO_DATA_WIDTH-1:0] fifo_data_t;

    // Address plus wrap flag in the top bit
    typedef logic [`DROP_FIFO_ADDR_WIDTH:0] fifo_ptr_t;

    // Occupancy or drop amount, 0 up to DEPTH
    typedef logic [`DROP_FIFO_ADDR_WIDTH:0] fifo_count_t;

    // Drop sequencing states
    typedef enum logic [1:0] {
        DROP_IDLE   = 2'b00,
        DROP_ACTIVE = 2'b01,
        DROP_SETTLE = 2'b10,
        DROP_DONE   = 2'b11
    } drop_state_t;

endpackage : drop_fifo_pkg

//--- verilog/drop_fifo_ptrs.sv
// FIFO pointer and flag unit
`timescale 1ns/1ps

`include "drop_fifo_defs.svh"

module drop_fifo_ptrs (
    input  logic                       axi_aclk,
    input  logic                       axi_aresetn,
    input  logic                       i_wr_valid,
    input  logic                       i_rd_ready,
    output logic                       o_wr_ready,
    output logic                       o_rd_valid,
    output drop_fifo_pkg::fifo_count_t o_count,
    drop_cmd_if.ptrs                   cmd,
    fifo_mem_if.ptrs                   mem
);

    // Pointers with wrap bit on top
    drop_fifo_pkg::fifo_ptr_t r_wr_ptr;
    drop_fifo_pkg::fifo_ptr_t r_rd_ptr;

    // Occupancy from the live pointers
    drop_fifo_pkg::fifo_count_t w_count;

    logic w_full;
    logic w_empty;

    // Transfer enables
    logic w_wr_en;
    logic w_rd_en;

    // ------------------------------
    // Status
    // ------------------------------

    // Modulo difference, wrap bit keeps 0 and DEPTH apart
    assign w_count = drop_fifo_pkg::fifo_count_t'(r_wr_ptr - r_rd_ptr);

    // Same address, opposite lap
    assign w_full = (r_wr_ptr[`DROP_FIFO_ADDR_WIDTH] != r_rd_ptr[`DROP_FIFO_ADDR_WIDTH]) &&
                    (r_wr_ptr[`DROP_FIFO_ADDR_WIDTH-1:0] ==
                     r_rd_ptr[`DROP_FIFO_ADDR_WIDTH-1:0]);

    // Same address, same lap
    assign w_empty = (r_wr_ptr == r_rd_ptr);

    assign o_count = w_count;

    // ------------------------------
    // Port gating
    // ------------------------------

    // Nothing moves while a drop is in flight
    assign o_wr_ready = !w_full && !cmd.freeze;
    assign o_rd_valid = !w_empty && !cmd.freeze;

    assign w_wr_en = i_wr_valid && o_wr_ready;
    assign w_rd_en = o_rd_valid && i_rd_ready;

    // ------------------------------
    // Write pointer
    // ------------------------------
    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            r_wr_ptr <= '0;
        end else if (w_wr_en) begin
            r_wr_ptr <= r_wr_ptr + drop_fifo_pkg::fifo_ptr_t'(1);
        end
    end

    // ------------------------------
    // Read pointer
    // ------------------------------
    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            r_rd_ptr <= '0;
        end else if (cmd.adjust) begin
            // Reads are frozen here so the drop owns the pointer
            if (cmd.drop_all) begin
                // Catch up with the writer, FIFO goes empty
                r_rd_ptr <= r_wr_ptr;
            end else begin
                // Skip ahead, carry rolls into the wrap bit
                r_rd_ptr <= r_rd_ptr + drop_fifo_pkg::fifo_ptr_t'(cmd.drop_count);
            end
        end else if (w_rd_en) begin
            r_rd_ptr <= r_rd_ptr + drop_fifo_pkg::fifo_ptr_t'(1);
        end
    end

    // ------------------------------
    // Storage side
    // ------------------------------
    assign mem.wr_en   = w_wr_en;
    // Low bits index the array
    assign mem.wr_addr = r_wr_ptr[`DROP_FIFO_ADDR_WIDTH-1:0];
    // Read from the current pointer, no look-ahead
    assign mem.rd_addr = r_rd_ptr[`DROP_FIFO_ADDR_WIDTH-1:0];

endmodule : drop_fifo_ptrs

//--- verilog/drop_fifo_top.sv
// Drop FIFO top level
`timescale 1ns/1ps

module drop_fifo_top (
    input  logic                       axi_aclk,
    input  logic                       axi_aresetn,

    // Write port
    input  logic                       i_wr_valid,
    output logic                       o_wr_ready,
    input  drop_fifo_pkg::fifo_data_t  i_wr_data,

    // Read port
    input  logic                       i_rd_ready,
    output logic                       o_rd_valid,
    output drop_fifo_pkg::fifo_data_t  o_rd_data,

    // Occupancy
    output drop_fifo_pkg::fifo_count_t o_count,

    // Drop request port
    input  logic                       i_drop_valid,
    output logic                       o_drop_ready,
    input  drop_fifo_pkg::fifo_count_t i_drop_count,
    input  logic                       i_drop_all
);

    // ------------------------------
    // Internal buses
    // ------------------------------
    drop_cmd_if u_cmd_if ();
    fifo_mem_if u_mem_if ();

    // Data legs go straight to the array
    assign u_mem_if.wr_data = i_wr_data;
    assign o_rd_data        = u_mem_if.rd_data;

    // ------------------------------
    // Drop sequencing
    // ------------------------------
    drop_fifo_ctrl u_ctrl (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .i_drop_valid (i_drop_valid),
        .i_drop_all   (i_drop_all),
        .i_drop_count (i_drop_count),
        .o_drop_ready (o_drop_ready),
        .cmd          (u_cmd_if.ctrl)
    );

    // ------------------------------
    // Pointers, flags, gating
    // ------------------------------
    drop_fifo_ptrs u_ptrs (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .i_wr_valid  (i_wr_valid),
        .i_rd_ready  (i_rd_ready),
        .o_wr_ready  (o_wr_ready),
        .o_rd_valid  (o_rd_valid),
        .o_count     (o_count),
        .cmd         (u_cmd_if.ptrs),
        .mem         (u_mem_if.ptrs)
    );

    // ------------------------------
    // Storage
    // ------------------------------
    drop_fifo_mem u_mem (
        .axi_aclk (axi_aclk),
        .mem      (u_mem_if.mem)
    );

endmodule : drop_fifo_top
